// File: dv/fmcadc2_ctrl_tb.sv
// Testbench for the FMC ADC slow-control top: SPI pin routing, SDIO turnaround, records, SYSREF
`timescale 1ns/10ps
`include "fmc_ctrl_defines.svh"

module fmcadc2_ctrl_tb;
  import fmc_ctrl_pkg::*;

  // One SPI transfer and the record it is expected to leave behind
  typedef struct packed {
    logic [7:0]  csn;
    logic        mode;
    logic [5:0]  bits;
    logic        read;
    spi_target_e rec;
    logic [31:0] word;
  } xfer_t;

  localparam int NUM_XFERS = 8;
  localparam int HALF_CYC  = 8;

  logic       sys_clk;
  logic       reset_i;
  logic [7:0] spi_csn;
  logic       spi_clk;
  logic       spi_mosi;
  logic       pll_mode;
  logic       pll_ce;
  logic       sysref_en;
  logic       adc_sdio_in;
  logic       spi_miso;
  logic       adc_csn;
  logic       adc_clk;
  logic       adc_sdio;
  logic       adc_sdio_oe;
  logic       pll_pin0;
  logic       pll_pin1;
  logic       pll_pin2;
  logic       pll_pin3;
  logic       sysref;
  logic       wr_valid;
  wr_record_t adc_rec;
  wr_record_t pll_rec;

  xfer_t      xfers [NUM_XFERS];
  wr_record_t exp_adc;
  wr_record_t exp_pll;
  logic       turned;
  integer     seed = 32'h12b30803;
  int         err_cnt = 0;

  fmcadc2_ctrl_top u_dut (
    .sys_clk       (sys_clk),
    .reset_i       (reset_i),
    .spi_csn_i     (spi_csn),
    .spi_clk_i     (spi_clk),
    .spi_mosi_i    (spi_mosi),
    .spi_miso_o    (spi_miso),
    .pll_mode_i    (pll_mode),
    .pll_ce_i      (pll_ce),
    .sysref_en_i   (sysref_en),
    .adc_sdio_i    (adc_sdio_in),
    .adc_csn_o     (adc_csn),
    .adc_clk_o     (adc_clk),
    .adc_sdio_o    (adc_sdio),
    .adc_sdio_oe_o (adc_sdio_oe),
    .pll_pin0_o    (pll_pin0),
    .pll_pin1_o    (pll_pin1),
    .pll_pin2_o    (pll_pin2),
    .pll_pin3_o    (pll_pin3),
    .sysref_o      (sysref),
    .wr_valid_o    (wr_valid),
    .adc_rec_o     (adc_rec),
    .pll_rec_o     (pll_rec)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  // ********************
  // Helpers
  // ********************

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge sys_clk);
    #1;
  endtask

  task automatic fail_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [7:0] cs_mask(input int idx);
    return ~(8'd1 << idx);
  endfunction

  // Expected pin levels come straight from the board wiring rules
  task automatic check_pins();
    logic one_low;
    logic adc_sel;
    logic pll_sel;
    logic aux_sel;
    one_low = ($countones(~spi_csn) == 1);
    adc_sel = one_low && !spi_csn[`SPI_CS_ADC];
    pll_sel = one_low && !spi_csn[`SPI_CS_PLL];
    aux_sel = one_low && !spi_csn[`SPI_CS_AUX];
    check_value("adc_csn_o", adc_csn, !adc_sel);
    check_value("adc_clk_o", adc_clk, spi_clk);
    check_value("adc_sdio_o", adc_sdio, spi_mosi);
    if (pll_mode) begin
      check_value("pll_pin0_o", pll_pin0, spi_mosi);
      check_value("pll_pin1_o", pll_pin1, spi_clk);
      check_value("pll_pin2_o", pll_pin2, pll_sel);
      check_value("pll_pin3_o", pll_pin3, pll_ce);
    end else begin
      check_value("pll_pin0_o", pll_pin0, !pll_sel);
      check_value("pll_pin1_o", pll_pin1, !aux_sel);
      check_value("pll_pin2_o", pll_pin2, spi_clk);
      check_value("pll_pin3_o", pll_pin3, spi_mosi);
    end
    check_value("adc_sdio_oe_o", adc_sdio_oe, !turned);
    check_value("spi_miso_o", spi_miso, turned & adc_sdio_in);
  endtask

  task automatic wait_oe_drop();
    int n;
    n = 0;
    while (adc_sdio_oe !== 1'b0) begin
      if (n == 3) fail_run("adc_sdio_oe_o never dropped after the ADC instruction phase");
      wait_cycles(1);
      n++;
    end
    turned = 1'b1;
  endtask

  task automatic wait_wr_valid(input logic expected);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < 4) begin
      wait_cycles(1);
      n++;
      seen = wr_valid;
    end
    if (expected && !seen) fail_run("wr_valid_o never came after the chip select was released");
    if (!expected && seen) fail_run("wr_valid_o pulsed for a transfer that is not a write");
  endtask

  // SPI master shifting MSB first, with data changing while the clock is low
  task automatic send_xfer(input xfer_t x);
    spi_csn  = x.csn;
    pll_mode = x.mode;
    pll_ce   = $random(seed);
    wait_cycles(HALF_CYC);
    for (int i = 0; i < x.bits; i++) begin
      spi_mosi    = x.word[31 - i];
      adc_sdio_in = $random(seed);
      wait_cycles(HALF_CYC / 2);
      check_pins();
      wait_cycles(HALF_CYC / 2);
      spi_clk = 1'b1;
      if (x.read && i == `ADC_INSTR_BITS - 1) wait_oe_drop();
      wait_cycles(HALF_CYC / 2);
      check_pins();
      wait_cycles(HALF_CYC / 2);
      spi_clk = 1'b0;
    end
    wait_cycles(HALF_CYC);
    spi_csn  = 8'hFF;
    spi_mosi = 1'b0;
    turned   = 1'b0;
    wait_wr_valid(x.rec != TGT_NONE);
    check_pins();
  endtask

  task automatic wait_sysref(input logic lvl, input int max_cycles, output int n);
    n = 0;
    while (sysref !== lvl) begin
      if (n == max_cycles) fail_run("sysref_o never reached the expected level");
      wait_cycles(1);
      n++;
    end
  endtask

  // ********************
  // Main sequence
  // ********************

  initial begin
    int w;
    int g;
    reset_i     = 1'b1;
    spi_csn     = 8'hFF;
    spi_clk     = 1'b0;
    spi_mosi    = 1'b0;
    pll_mode    = 1'b0;
    pll_ce      = 1'b0;
    sysref_en   = 1'b0;
    adc_sdio_in = 1'b0;
    turned      = 1'b0;
    exp_adc     = '0;
    exp_pll     = '0;

    // Columns are chip selects, PLL mode, bit count, read, expected record, word
    xfers[0] = '{cs_mask(`SPI_CS_ADC), 1'b1, 6'd24, 1'b0, TGT_ADC, '0};
    xfers[1] = '{cs_mask(`SPI_CS_ADC), 1'b1, 6'd24, 1'b1, TGT_NONE, '0};
    xfers[2] = '{cs_mask(`SPI_CS_PLL), 1'b1, 6'd32, 1'b0, TGT_PLL, '0};
    xfers[3] = '{cs_mask(`SPI_CS_PLL), 1'b0, 6'd32, 1'b0, TGT_PLL, '0};
    xfers[4] = '{cs_mask(`SPI_CS_PLL), 1'b0, 6'd20, 1'b0, TGT_NONE, '0};
    xfers[5] = '{cs_mask(`SPI_CS_ADC) & cs_mask(`SPI_CS_PLL), 1'b0, 6'd24, 1'b0, TGT_NONE, '0};
    xfers[6] = '{cs_mask(`SPI_CS_AUX), 1'b0, 6'd32, 1'b0, TGT_NONE, '0};
    xfers[7] = '{cs_mask(`SPI_CS_ADC), 1'b0, 6'd24, 1'b0, TGT_ADC, '0};
    for (int k = 0; k < NUM_XFERS; k++) begin
      xfers[k].word = $random(seed);
      if (xfers[k].csn == cs_mask(`SPI_CS_ADC)) xfers[k].word[31] = xfers[k].read;
    end

    wait_cycles(10);
    reset_i = 1'b0;
    wait_cycles(2);
    check_value("adc_sdio_oe_o", adc_sdio_oe, 1'b1);
    check_value("wr_valid_o", wr_valid, 1'b0);
    check_value("sysref_o", sysref, 1'b0);
    check_value("adc_rec_o", adc_rec, '0);
    check_value("pll_rec_o", pll_rec, '0);

    for (int k = 0; k < NUM_XFERS; k++) begin
      send_xfer(xfers[k]);
      if (xfers[k].rec == TGT_ADC) begin
        exp_adc.target = TGT_ADC;
        exp_adc.addr   = {1'b0, xfers[k].word[30:16]};
        exp_adc.data   = {20'd0, xfers[k].word[15:8]};
      end else if (xfers[k].rec == TGT_PLL) begin
        exp_pll.target = TGT_PLL;
        exp_pll.addr   = {12'd0, xfers[k].word[3:0]};
        exp_pll.data   = xfers[k].word[31:4];
      end
      check_value("adc_rec_o", adc_rec, exp_adc);
      check_value("pll_rec_o", pll_rec, exp_pll);
    end

    // SYSREF pulses start one cycle after the enable and repeat every period
    sysref_en = 1'b1;
    wait_sysref(1'b1, 4, g);
    check_value("sysref_o start delay", g, 1);
    for (int p = 0; p < 3; p++) begin
      wait_sysref(1'b0, `SYSREF_WIDTH + 2, w);
      check_value("sysref_o width", w, `SYSREF_WIDTH);
      wait_sysref(1'b1, `SYSREF_PERIOD + 2, g);
      check_value("sysref_o period", w + g, `SYSREF_PERIOD);
    end
    // A pulse cut off by the enable still runs to its full width
    sysref_en = 1'b0;
    wait_sysref(1'b0, `SYSREF_WIDTH + 2, w);
    check_value("sysref_o last width", w, `SYSREF_WIDTH);
    for (int c = 0; c < 2 * `SYSREF_PERIOD; c++) begin
      wait_cycles(1);
      if (sysref !== 1'b0) fail_run("sysref_o pulsed again after the enable fell");
    end

    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+verilog
verilog/fmc_ctrl_pkg.sv
verilog/spi_cs_decode.sv
verilog/spi_sdio_ctrl.sv
verilog/spi_write_capture.sv
verilog/sysref_gen.sv
verilog/fmcadc2_ctrl_top.sv
dv/fmcadc2_ctrl_tb.sv

// File: verilog/fmc_ctrl_defines.svh
// FMC ADC slow-control constants for chip-select indices, SPI word lengths and SYSREF timing
`ifndef FMC_CTRL_DEFINES_SVH
`define FMC_CTRL_DEFINES_SVH

// ********************
// SPI chip-select map
// ********************

// Index into the processor's eight active-low chip selects
`define SPI_CS_ADC 0
`define SPI_CS_PLL 1
// Second device of the four-wire ADF4355 chain
`define SPI_CS_AUX 2

// ********************
// SPI word lengths
// ********************

// ADC instruction phase is R/W plus a 15-bit address
`define ADC_INSTR_BITS 16
`define ADC_WORD_BITS 24
`define PLL_WORD_BITS 32

// ********************
// SYSREF timing
// ********************

// Both counts are in sys_clk cycles
`define SYSREF_PERIOD 64
`define SYSREF_WIDTH 4

`endif

// File: verilog/fmc_ctrl_pkg.sv
// Shared types for the FMC ADC slow-control path: SPI route, shifted word and write records
package fmc_ctrl_pkg;

  // ********************
  // Addressed device
  // ********************

  typedef enum logic [1:0] {
    TGT_NONE = 2'd0,
    TGT_ADC  = 2'd1,
    TGT_PLL  = 2'd2,
    TGT_AUX  = 2'd3
  } spi_target_e;

  // Result of the chip-select decode
  typedef struct packed {
    spi_target_e target;
    logic        active;
  } spi_route_t;

  // ********************
  // Shifted SPI word
  // ********************

  // ADC transfer, MSB first: R/W, address, then one data byte
  typedef struct packed {
    logic        rw;
    logic [14:0] addr;
    logic [7:0]  data;
    logic [7:0]  unused;
  } adc_word_t;

  // ADF4355 register word, control bits sit in the LSBs
  typedef struct packed {
    logic [27:0] data;
    logic [3:0]  ctrl;
  } pll_word_t;

  // The same 32 shifted bits, seen as either device's format
  typedef union packed {
    adc_word_t adc;
    pll_word_t pll;
  } spi_word_u;

  // ********************
  // Last-write record
  // ********************

  // Address holds the ADC register address or the PLL control field
  typedef struct packed {
    spi_target_e target;
    logic [15:0] addr;
    logic [27:0] data;
  } wr_record_t;

endpackage

// File: verilog/fmcadc2_ctrl_top.sv
// FMC ADC board slow-control top: SPI routing, SDIO turnaround, write capture and SYSREF
`timescale 1ns/10ps

module fmcadc2_ctrl_top (
  input  logic                     sys_clk,
  input  logic                     reset_i,
  input  logic [7:0]               spi_csn_i,
  input  logic                     spi_clk_i,
  input  logic                     spi_mosi_i,
  output logic                     spi_miso_o,
  input  logic                     pll_mode_i,
  input  logic                     pll_ce_i,
  input  logic                     sysref_en_i,
  input  logic                     adc_sdio_i,
  output logic                     adc_csn_o,
  output logic                     adc_clk_o,
  output logic                     adc_sdio_o,
  output logic                     adc_sdio_oe_o,
  output logic                     pll_pin0_o,
  output logic                     pll_pin1_o,
  output logic                     pll_pin2_o,
  output logic                     pll_pin3_o,
  output logic                     sysref_o,
  output logic                     wr_valid_o,
  output fmc_ctrl_pkg::wr_record_t adc_rec_o,
  output fmc_ctrl_pkg::wr_record_t pll_rec_o
);
  import fmc_ctrl_pkg::*;

  spi_route_t  route;
  logic        adc_read;
  logic        word_done;
  spi_word_u   word;
  logic [5:0]  bit_cnt;
  spi_target_e target;

  spi_cs_decode u_cs_decode (
    .spi_csn_i  (spi_csn_i),
    .spi_clk_i  (spi_clk_i),
    .spi_mosi_i (spi_mosi_i),
    .pll_mode_i (pll_mode_i),
    .pll_ce_i   (pll_ce_i),
    .adc_sdio_i (adc_sdio_i),
    .adc_read_i (adc_read),
    .route_o    (route),
    .adc_csn_o  (adc_csn_o),
    .adc_clk_o  (adc_clk_o),
    .adc_sdio_o (adc_sdio_o),
    .pll_pin0_o (pll_pin0_o),
    .pll_pin1_o (pll_pin1_o),
    .pll_pin2_o (pll_pin2_o),
    .pll_pin3_o (pll_pin3_o),
    .spi_miso_o (spi_miso_o)
  );

  spi_sdio_ctrl u_sdio_ctrl (
    .sys_clk       (sys_clk),
    .reset_i       (reset_i),
    .route_i       (route),
    .spi_clk_i     (spi_clk_i),
    .spi_mosi_i    (spi_mosi_i),
    .adc_sdio_oe_o (adc_sdio_oe_o),
    .adc_read_o    (adc_read),
    .word_done_o   (word_done),
    .word_o        (word),
    .bit_cnt_o     (bit_cnt),
    .target_o      (target)
  );

  spi_write_capture u_write_capture (
    .sys_clk     (sys_clk),
    .reset_i     (reset_i),
    .word_done_i (word_done),
    .word_i      (word),
    .bit_cnt_i   (bit_cnt),
    .target_i    (target),
    .adc_rec_o   (adc_rec_o),
    .pll_rec_o   (pll_rec_o),
    .wr_valid_o  (wr_valid_o)
  );

  sysref_gen u_sysref_gen (
    .sys_clk     (sys_clk),
    .reset_i     (reset_i),
    .sysref_en_i (sysref_en_i),
    .sysref_o    (sysref_o)
  );

endmodule

// File: verilog/spi_cs_decode.sv
// SPI chip-select decoder that routes the shared bus onto the ADC and ADF4355 pins
`timescale 1ns/10ps
`include "fmc_ctrl_defines.svh"

module spi_cs_decode (
  input  logic [7:0]               spi_csn_i,
  input  logic                     spi_clk_i,
  input  logic                     spi_mosi_i,
  input  logic                     pll_mode_i,
  input  logic                     pll_ce_i,
  input  logic                     adc_sdio_i,
  input  logic                     adc_read_i,
  output fmc_ctrl_pkg::spi_route_t route_o,
  output logic                     adc_csn_o,
  output logic                     adc_clk_o,
  output logic                     adc_sdio_o,
  output logic                     pll_pin0_o,
  output logic                     pll_pin1_o,
  output logic                     pll_pin2_o,
  output logic                     pll_pin3_o,
  output logic                     spi_miso_o
);
  import fmc_ctrl_pkg::*;

  logic [7:0] csn_low;
  logic       single_low;
  logic       pll_csn;
  logic       aux_csn;

  // A route only exists when exactly one select is low
  assign csn_low    = ~spi_csn_i;
  assign single_low = (csn_low != 8'd0) && ((csn_low & (csn_low - 8'd1)) == 8'd0);

  always_comb begin
    route_o = '{target: TGT_NONE, active: 1'b0};
    if (single_low) begin
      if (csn_low[`SPI_CS_ADC]) route_o.target = TGT_ADC;
      else if (csn_low[`SPI_CS_PLL]) route_o.target = TGT_PLL;
      else if (csn_low[`SPI_CS_AUX]) route_o.target = TGT_AUX;
      // Selects without a device on this board stay unrouted
      route_o.active = (route_o.target != TGT_NONE);
    end
  end

  // ********************
  // Pin wiring
  // ********************

  assign adc_csn_o  = (route_o.target != TGT_ADC);
  assign adc_clk_o  = spi_clk_i;
  assign adc_sdio_o = spi_mosi_i;

  assign pll_csn = (route_o.target != TGT_PLL);
  assign aux_csn = (route_o.target != TGT_AUX);

  // Mode 1 is the three-wire port with LE, mode 0 the four-wire chain
  assign pll_pin0_o = pll_mode_i ? spi_mosi_i : pll_csn;
  assign pll_pin1_o = pll_mode_i ? spi_clk_i : aux_csn;
  assign pll_pin2_o = pll_mode_i ? ~pll_csn : spi_clk_i;
  assign pll_pin3_o = pll_mode_i ? pll_ce_i : spi_mosi_i;

  // Read data only comes back from the ADC after turnaround
  assign spi_miso_o = (route_o.target == TGT_ADC) && adc_read_i && adc_sdio_i;

  // The ADC must stay deselected whenever the processor also holds the PLL select low
  a_no_dual_select: assert property (@(posedge spi_clk_i)
    !(!adc_csn_o && !spi_csn_i[`SPI_CS_PLL]));

endmodule

// File: verilog/spi_sdio_ctrl.sv
// SPI execute block: samples the bus, shifts in the word and turns the ADC SDIO around
`timescale 1ns/10ps
`include "fmc_ctrl_defines.svh"

module spi_sdio_ctrl (
  input  logic                      sys_clk,
  input  logic                      reset_i,
  input  fmc_ctrl_pkg::spi_route_t  route_i,
  input  logic                      spi_clk_i,
  input  logic                      spi_mosi_i,
  output logic                      adc_sdio_oe_o,
  output logic                      adc_read_o,
  output logic                      word_done_o,
  output fmc_ctrl_pkg::spi_word_u   word_o,
  output logic [5:0]                bit_cnt_o,
  output fmc_ctrl_pkg::spi_target_e target_o
);
  import fmc_ctrl_pkg::*;

  spi_route_t  route_s1_q;
  spi_route_t  route_s2_q;
  logic [2:0]  sclk_q;
  logic [1:0]  mosi_q;
  logic        sclk_rise;
  logic        xfer_start;
  logic        xfer_end;
  logic        shift_en;
  logic        xfer_active_q;
  logic        adc_read_q;
  logic [5:0]  bit_cnt_q;
  spi_word_u   word_q;
  spi_target_e target_q;

  // ********************
  // Synchronizers
  // ********************

  // Two stages for each input, the third clock bit is edge history
  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      route_s1_q <= '0;
      route_s2_q <= '0;
      sclk_q     <= 3'd0;
      mosi_q     <= 2'd0;
    end else begin
      route_s1_q <= route_i;
      route_s2_q <= route_s1_q;
      sclk_q     <= {sclk_q[1:0], spi_clk_i};
      mosi_q     <= {mosi_q[0], spi_mosi_i};
    end
  end

  assign sclk_rise  = sclk_q[1] & ~sclk_q[2];
  assign xfer_start = route_s2_q.active & ~xfer_active_q;
  assign xfer_end   = ~route_s2_q.active & xfer_active_q;

  // Extra bits past a full PLL word are dropped
  assign shift_en = xfer_active_q & route_s2_q.active & sclk_rise &
                    (bit_cnt_q != 6'(`PLL_WORD_BITS));

  // ********************
  // Transfer control
  // ********************

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      xfer_active_q <= 1'b0;
      adc_read_q    <= 1'b0;
      bit_cnt_q     <= 6'd0;
      target_q      <= TGT_NONE;
    end else if (xfer_start) begin
      xfer_active_q <= 1'b1;
      adc_read_q    <= 1'b0;
      bit_cnt_q     <= 6'd0;
      target_q      <= route_s2_q.target;
    end else if (xfer_end) begin
      xfer_active_q <= 1'b0;
      adc_read_q    <= 1'b0;
    end else if (shift_en) begin
      bit_cnt_q <= bit_cnt_q + 6'd1;
      // Release SDIO on the last instruction bit so the ADC can drive the data phase
      if ((target_q == TGT_ADC) && (bit_cnt_q == 6'(`ADC_INSTR_BITS - 1)) &&
          word_q.adc.rw) begin
        adc_read_q <= 1'b1;
      end
    end
  end

  // Bits land MSB first so both union views line up for any length
  always_ff @(posedge sys_clk) begin
    if (xfer_start) begin
      word_q <= '0;
    end else if (shift_en) begin
      word_q[5'd31 - bit_cnt_q[4:0]] <= mosi_q[1];
    end
  end

  assign adc_sdio_oe_o = ~adc_read_q;
  assign adc_read_o    = adc_read_q;
  assign word_done_o   = xfer_end;
  assign word_o        = word_q;
  assign bit_cnt_o     = bit_cnt_q;
  assign target_o      = target_q;

  // The FPGA owns SDIO between transfers
  a_oe_idle: assert property (@(posedge sys_clk) disable iff (reset_i)
    !xfer_active_q |-> adc_sdio_oe_o);

  a_bit_cnt_max: assert property (@(posedge sys_clk) disable iff (reset_i)
    bit_cnt_q <= 6'(`PLL_WORD_BITS));

endmodule

// File: verilog/spi_write_capture.sv
// Write capture: decodes finished SPI words and keeps the last write for each device
`timescale 1ns/10ps
`include "fmc_ctrl_defines.svh"

module spi_write_capture (
  input  logic                      sys_clk,
  input  logic                      reset_i,
  input  logic                      word_done_i,
  input  fmc_ctrl_pkg::spi_word_u   word_i,
  input  logic [5:0]                bit_cnt_i,
  input  fmc_ctrl_pkg::spi_target_e target_i,
  output fmc_ctrl_pkg::wr_record_t  adc_rec_o,
  output fmc_ctrl_pkg::wr_record_t  pll_rec_o,
  output logic                      wr_valid_o
);
  import fmc_ctrl_pkg::*;

  logic       adc_wr;
  logic       pll_wr;
  wr_record_t adc_rec_d;
  wr_record_t pll_rec_d;
  wr_record_t adc_rec_q;
  wr_record_t pll_rec_q;
  logic       wr_valid_q;

  // ********************
  // Write decode
  // ********************

  // Only full-length words count, ADC reads never update a record
  assign adc_wr = word_done_i && (target_i == TGT_ADC) &&
                  (bit_cnt_i == 6'(`ADC_WORD_BITS)) && !word_i.adc.rw;
  assign pll_wr = word_done_i && (target_i == TGT_PLL) &&
                  (bit_cnt_i == 6'(`PLL_WORD_BITS));

  always_comb begin
    adc_rec_d.target = TGT_ADC;
    adc_rec_d.addr   = {1'b0, word_i.adc.addr};
    adc_rec_d.data   = {20'd0, word_i.adc.data};

    pll_rec_d.target = TGT_PLL;
    pll_rec_d.addr   = {12'd0, word_i.pll.ctrl};
    pll_rec_d.data   = word_i.pll.data;
  end

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      adc_rec_q  <= '0;
      pll_rec_q  <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= adc_wr | pll_wr;
      if (adc_wr) begin
        adc_rec_q <= adc_rec_d;
      end
      if (pll_wr) begin
        pll_rec_q <= pll_rec_d;
      end
    end
  end

  assign adc_rec_o  = adc_rec_q;
  assign pll_rec_o  = pll_rec_q;
  assign wr_valid_o = wr_valid_q;

  // Each transfer ends once, so two back-to-back records point at a broken done strobe
  a_wr_valid_pulse: assert property (@(posedge sys_clk) disable iff (reset_i)
    wr_valid_o |=> !wr_valid_o);

endmodule

// File: verilog/sysref_gen.sv
// SYSREF generator that emits a periodic fixed-width pulse while the GPIO enable is set
`timescale 1ns/10ps
`include "fmc_ctrl_defines.svh"

module sysref_gen (
  input  logic sys_clk,
  input  logic reset_i,
  input  logic sysref_en_i,
  output logic sysref_o
);

  localparam int CNT_W = $clog2(`SYSREF_PERIOD);

  logic             en_q;
  logic             run_q;
  logic [CNT_W-1:0] cnt_q;

  // ********************
  // Period counter
  // ********************

  always_ff @(posedge sys_clk) begin
    if (reset_i) begin
      en_q  <= 1'b0;
      run_q <= 1'b0;
      cnt_q <= '0;
    end else begin
      en_q <= sysref_en_i;
      if (sysref_en_i && !en_q) begin
        // A fresh enable restarts the period at its first pulse cycle
        run_q <= 1'b1;
        cnt_q <= '0;
      end else if (run_q) begin
        cnt_q <= (cnt_q == CNT_W'(`SYSREF_PERIOD - 1)) ? '0 : cnt_q + 1'b1;
        // Once disabled, stop after the pulse in flight is complete
        if (!sysref_en_i && (cnt_q >= CNT_W'(`SYSREF_WIDTH - 1))) begin
          run_q <= 1'b0;
        end
      end
    end
  end

  assign sysref_o = run_q && (cnt_q < CNT_W'(`SYSREF_WIDTH));

endmodule
